// File: build.f
+incdir+logic
logic/fetch_pkg.sv
logic/decode_pkg.sv
logic/fetch_stream_if.sv
logic/fetch_unit.sv
logic/instr_buffer.sv
logic/decode_stage.sv
logic/fetch_frontend.sv
sim/tb_fetch_frontend.sv

// File: Makefile
SRCS := $(shell grep '\.sv$$' build.f) $(wildcard logic/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_fetch_frontend
	@out="$$(./obj_dir/Vtb_fetch_frontend)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

obj_dir/Vtb_fetch_frontend: build.f $(SRCS)
	verilator --binary --timing -f build.f --top-module tb_fetch_frontend \
		-Mdir obj_dir -o Vtb_fetch_frontend

clean:
	rm -rf obj_dir

// File: sim/tb_fetch_frontend.sv
// drives the front end with a synthetic memory; assumes one-cycle memory latency, seed is fixed
`timescale 1ns/10ps
`default_nettype none

`include "frontend_defs.svh"

module tb_fetch_frontend import fetch_pkg::*, decode_pkg::*; ();

  logic        clk;
  logic        rst_n;
  logic        redirect_i;
  pc_t         redirect_pc_i;
  logic        imem_req_o;
  pc_t         imem_addr_o;
  instr_t      imem_data_i;
  logic        dec_valid_o;
  logic        dec_ready_i;
  pc_t         dec_pc_o;
  op_class_t   dec_op_o;
  reg_idx_t    dec_rd_o;
  reg_idx_t    dec_rs1_o;
  logic [31:0] dec_imm_o;

  logic [31:0] rng_state;
  logic        long_stall;
  logic        redirect_en;
  logic        req_seen;
  pc_t         addr_seen;
  logic        first_req;
  logic        hold_chk;
  decoded_t    held;
  pc_t         exp_pc;
  logic [4:0]  class_seen;
  logic [3:0]  sign_seen;
  logic        timed_out;
  int          errors;
  int          accepted;
  int          redirects;

  fetch_frontend i_fetch_frontend (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_data_i   (imem_data_i),
    .dec_valid_o   (dec_valid_o),
    .dec_ready_i   (dec_ready_i),
    .dec_pc_o      (dec_pc_o),
    .dec_op_o      (dec_op_o),
    .dec_rd_o      (dec_rd_o),
    .dec_rs1_o     (dec_rs1_o),
    .dec_imm_o     (dec_imm_o)
  );

  always #50 clk = ~clk;

  // ==================================================
  // models and reference
  // ==================================================
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // opcodes 0..4 in turn, other fields hashed from the whole address
  function automatic instr_t mem_word(input pc_t addr);
    logic [31:0] mix;
    logic [5:0]  op;
    mix = (addr * 32'h9E37_79B1) ^ (addr >> 11);
    op  = 6'((addr >> 2) % 32'd5);
    return {op, mix[25:0]};
  endfunction

  function automatic decoded_t ref_decode(input pc_t pc);
    instr_t   w;
    decoded_t d;
    w     = mem_word(pc);
    d     = '0;
    d.pc  = pc;
    d.rd  = w[4:0];
    d.rs1 = w[9:5];
    d.op  = OP_INVALID;
    if (w[31:26] == 6'd0) begin
      d.op = OP_ALU;
    end else if (w[31:26] == 6'd1 || w[31:26] == 6'd2) begin
      d.op  = (w[31:26] == 6'd1) ? OP_ALUI : OP_LOAD;
      d.imm = 32'($signed(w[21:10]));
    end else if (w[31:26] == 6'd3) begin
      d.op  = OP_BRANCH;
      // byte offset of a signed word count
      d.imm = 32'($signed(w[25:10])) << 2;
    end
    return d;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("ERROR %s: got %h, expected %h at %0t", name, got, want, $time);
      errors++;
    end
  endtask

  task automatic wait_accepted(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (!timed_out && accepted < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && accepted < target) begin
      $display("timeout: only %0d of %0d outputs accepted after %0d cycles",
               accepted, target, cycles);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // memory answers the request seen in the cycle before the edge
  always @(negedge clk) begin
    req_seen  = imem_req_o;
    addr_seen = imem_addr_o;
  end

  always @(posedge clk) begin
    logic [31:0] r;
    logic [31:0] r_pc;
    if (req_seen) begin
      imem_data_i <= mem_word(addr_seen);
    end
    if (!rst_n) begin
      dec_ready_i <= 1'b0;
      redirect_i  <= 1'b0;
    end else begin
      r = lcg_next();
      dec_ready_i <= !long_stall && (r[31:16] % 16'd3 != 16'd0);
      r    = lcg_next();
      r_pc = lcg_next();
      if (redirect_en && !redirect_i && r[31:26] == 6'd0) begin
        redirect_i    <= 1'b1;
        redirect_pc_i <= {r_pc[31:2], 2'b00};
      end else begin
        redirect_i <= 1'b0;
      end
    end
  end

  // ==================================================
  // comparison
  // ==================================================
  always @(negedge clk) begin
    decoded_t want;
    if (!rst_n) begin
      if (dec_valid_o) begin
        $display("dec_valid_o is high during reset at %0t", $time);
        errors++;
      end
      if (imem_req_o) begin
        $display("imem_req_o is high during reset at %0t", $time);
        errors++;
      end
    end else begin
      if (first_req && imem_req_o) begin
        check_value("imem_addr_o", imem_addr_o, `FRONTEND_RESET_PC);
        first_req = 1'b0;
      end
      if (redirect_i && imem_req_o) begin
        $display("memory request issued in a redirect cycle at %0t", $time);
        errors++;
      end
      // outputs must not move while stalled
      if (hold_chk) begin
        check_value("dec_valid_o", 32'(dec_valid_o), 32'(1'b1));
        check_value("dec_pc_o", dec_pc_o, held.pc);
        check_value("dec_op_o", 32'(dec_op_o), 32'(held.op));
        check_value("dec_rd_o", 32'(dec_rd_o), 32'(held.rd));
        check_value("dec_rs1_o", 32'(dec_rs1_o), 32'(held.rs1));
        check_value("dec_imm_o", dec_imm_o, held.imm);
      end
      if (dec_valid_o && dec_ready_i) begin
        want = ref_decode(exp_pc);
        check_value("dec_pc_o", dec_pc_o, want.pc);
        check_value("dec_op_o", 32'(dec_op_o), 32'(want.op));
        check_value("dec_rd_o", 32'(dec_rd_o), 32'(want.rd));
        check_value("dec_rs1_o", 32'(dec_rs1_o), 32'(want.rs1));
        check_value("dec_imm_o", dec_imm_o, want.imm);
        class_seen[want.op] = 1'b1;
        if (want.op == OP_ALUI || want.op == OP_LOAD) begin
          sign_seen[{1'b0, want.imm[31]}] = 1'b1;
        end else if (want.op == OP_BRANCH) begin
          sign_seen[{1'b1, want.imm[31]}] = 1'b1;
        end
        accepted++;
        exp_pc = exp_pc + 32'd4;
      end
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
        redirects++;
      end
      hold_chk = dec_valid_o && !dec_ready_i && !redirect_i;
      held     = '{pc: dec_pc_o, op: dec_op_o, rd: dec_rd_o, rs1: dec_rs1_o,
                   imm: dec_imm_o};
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    imem_data_i   = '0;
    dec_ready_i   = 1'b0;
    rng_state     = 32'd27068;
    long_stall    = 1'b0;
    redirect_en   = 1'b0;
    req_seen      = 1'b0;
    addr_seen     = '0;
    first_req     = 1'b1;
    hold_chk      = 1'b0;
    held          = '0;
    exp_pc        = `FRONTEND_RESET_PC;
    class_seen    = '0;
    sign_seen     = '0;
    timed_out     = 1'b0;
    errors        = 0;
    accepted      = 0;
    redirects     = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // random stalls only, then a stall long enough to fill the buffer
    wait_accepted(120, 1500);
    long_stall <= 1'b1;
    repeat (30) @(posedge clk);
    long_stall <= 1'b0;
    wait_accepted(accepted + 60, 1000);

    // random redirects on top of random stalls
    redirect_en <= 1'b1;
    wait_accepted(accepted + 450, 5000);
    redirect_en <= 1'b0;

    if (class_seen != 5'b11111 || sign_seen != 4'b1111) begin
      $display("not every class or immediate sign was decoded: classes %b, signs %b",
               class_seen, sign_seen);
      errors++;
    end
    if (redirects == 0) begin
      $display("no redirect was issued");
      errors++;
    end
    $display("accepted %0d, redirects %0d, errors %0d", accepted, redirects, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_fetch_frontend

`default_nettype wire

// File: logic/fetch_frontend.sv
// single-issue front end; imem must return each word one edge after the request
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend import fetch_pkg::*, decode_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  // flush and restart
  input  wire logic   redirect_i,
  input  wire pc_t    redirect_pc_i,
  // instruction memory
  output logic        imem_req_o,
  output pc_t         imem_addr_o,
  input  wire instr_t imem_data_i,
  // decoded output
  output logic        dec_valid_o,
  input  wire logic   dec_ready_i,
  output pc_t         dec_pc_o,
  output op_class_t   dec_op_o,
  output reg_idx_t    dec_rd_o,
  output reg_idx_t    dec_rs1_o,
  output logic [31:0] dec_imm_o
);

  decoded_t dec_out;

  fetch_stream_if push_bus ();
  fetch_stream_if pop_bus ();

  // ==================================================
  // fetch, buffer, decode
  // ==================================================
  fetch_unit i_fetch_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_data_i   (imem_data_i),
    .push          (push_bus.producer)
  );

  instr_buffer i_instr_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .push       (push_bus.consumer),
    .pop        (pop_bus.producer)
  );

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect_i  (redirect_i),
    .pop         (pop_bus.consumer),
    .dec_valid_o (dec_valid_o),
    .dec_ready_i (dec_ready_i),
    .dec_out_o   (dec_out)
  );

  assign dec_pc_o  = dec_out.pc;
  assign dec_op_o  = dec_out.op;
  assign dec_rd_o  = dec_out.rd;
  assign dec_rs1_o = dec_out.rs1;
  assign dec_imm_o = dec_out.imm;

endmodule : fetch_frontend

`default_nettype wire

// File: logic/decode_stage.sv
// one-entry decode register; the output holds while valid and not accepted
`timescale 1ns/10ps
`default_nettype none

`include "frontend_defs.svh"

module decode_stage import fetch_pkg::*, decode_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic redirect_i,
  fetch_stream_if.consumer pop,
  output logic      dec_valid_o,
  input  wire logic dec_ready_i,
  output decoded_t  dec_out_o
);

  logic [`FRONTEND_OP_MSB-`FRONTEND_OP_LSB:0] op_field;

  op_class_t   op;
  imm_kind_t   kind;
  logic [31:0] imm;
  decoded_t    dec_next;
  decoded_t    out_q;
  logic        out_valid_q;
  logic        take;
  logic        fire;

  // ==================================================
  // pop control
  // ==================================================
  assign take     = ~out_valid_q | dec_ready_i;
  assign pop.ready = take & ~redirect_i;
  assign fire     = pop.valid & pop.ready;

  // ==================================================
  // decode
  // ==================================================
  assign op_field = pop.instr[`FRONTEND_OP_MSB:`FRONTEND_OP_LSB];

  always_comb begin
    case (op_field)
      6'd0:    begin op = OP_ALU;     kind = IMM_NONE;   end
      6'd1:    begin op = OP_ALUI;    kind = IMM_SI12;   end
      6'd2:    begin op = OP_LOAD;    kind = IMM_SI12;   end
      6'd3:    begin op = OP_BRANCH;  kind = IMM_OFFS16; end
      default: begin op = OP_INVALID; kind = IMM_NONE;   end
    endcase
  end

  always_comb begin
    case (kind)
      IMM_SI12:   imm = {{20{pop.instr[21]}}, pop.instr[21:10]};
      // word offset, scaled to bytes
      IMM_OFFS16: imm = {{14{pop.instr[25]}}, pop.instr[25:10], 2'b00};
      default:    imm = '0;
    endcase
  end

  assign dec_next = '{pc:  pop.pc,
                      op:  op,
                      rd:  pop.instr[`FRONTEND_RD_LSB +: $bits(reg_idx_t)],
                      rs1: pop.instr[`FRONTEND_RS1_LSB +: $bits(reg_idx_t)],
                      imm: imm};

  // ==================================================
  // output register
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (redirect_i) begin
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      out_q <= dec_next;
    end
  end

  assign dec_valid_o = out_valid_q;
  assign dec_out_o   = out_q;

endmodule : decode_stage

`default_nettype wire

// File: logic/instr_buffer.sv
// single-port FIFO; push ready needs two free slots, so one fetch may be in flight
`timescale 1ns/10ps
`default_nettype none

`include "frontend_defs.svh"

module instr_buffer import fetch_pkg::*; #(
  parameter int DEPTH = `FRONTEND_IBUF_DEPTH
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic redirect_i,
  fetch_stream_if.consumer push,
  fetch_stream_if.producer pop
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FREE_LIMIT = (PTR_W + 1)'(DEPTH - 2);

  fetch_entry_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  // ==================================================
  // handshakes
  // ==================================================
  assign do_push = push.valid & ~redirect_i;
  assign do_pop  = pop.valid & pop.ready & ~redirect_i;

  assign push.ready = (count <= FREE_LIMIT);

  assign pop.valid = (count != '0);
  assign pop.pc    = mem[rd_ptr].pc;
  assign pop.instr = mem[rd_ptr].instr;

  // ==================================================
  // storage and pointers
  // ==================================================
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= '{pc: push.pc, instr: push.instr};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (redirect_i) begin
      // flush drops everything queued
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + (PTR_W + 1)'(1);
        2'b01:   count <= count - (PTR_W + 1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule : instr_buffer

`default_nettype wire

// File: logic/fetch_unit.sv
// sequential fetch only; the instruction memory must answer every request on the next edge
`timescale 1ns/10ps
`default_nettype none

`include "frontend_defs.svh"

module fetch_unit import fetch_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   redirect_i,
  input  wire pc_t    redirect_pc_i,
  output logic        imem_req_o,
  output pc_t         imem_addr_o,
  input  wire instr_t imem_data_i,
  fetch_stream_if.producer push
);

  pc_t  pc_q;
  pc_t  pend_pc_q;
  logic pend_q;
  logic req;

  // buffer ready already leaves room for the word in flight
  // no request while held in reset
  assign req         = rst_n & push.ready & ~redirect_i;
  assign imem_req_o  = req;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q   <= `FRONTEND_RESET_PC;
      pend_q <= 1'b0;
    end else if (redirect_i) begin
      pc_q   <= redirect_pc_i;
      pend_q <= 1'b0;
    end else begin
      pend_q <= req;
      if (req) begin
        pc_q <= pc_q + `FRONTEND_PC_STEP;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      pend_pc_q <= pc_q;
    end
  end

  // returned word goes straight into the buffer
  assign push.valid = pend_q & ~redirect_i;
  assign push.pc    = pend_pc_q;
  assign push.instr = imem_data_i;

endmodule : fetch_unit

`default_nettype wire

// File: logic/fetch_stream_if.sv
// fetch entry stream; the meaning of ready depends on the link, see the modules on each side
`timescale 1ns/10ps
`default_nettype none

interface fetch_stream_if import fetch_pkg::*; ();

  logic   valid;
  logic   ready;
  pc_t    pc;
  instr_t instr;

  modport producer (
    output valid,
    output pc,
    output instr,
    input  ready
  );

  modport consumer (
    input  valid,
    input  pc,
    input  instr,
    output ready
  );

endinterface : fetch_stream_if

`default_nettype wire

// File: logic/decode_pkg.sv
// decode-side types; only four opcodes are known, every other opcode decodes as invalid
`default_nettype none

package decode_pkg;

  typedef enum logic [2:0] {
    OP_ALU     = 3'd0,
    OP_ALUI    = 3'd1,
    OP_LOAD    = 3'd2,
    OP_BRANCH  = 3'd3,
    OP_INVALID = 3'd4
  } op_class_t;

  // immediate layout inside the instruction word
  typedef enum logic [1:0] {
    IMM_NONE   = 2'd0,
    IMM_SI12   = 2'd1,
    IMM_OFFS16 = 2'd2
  } imm_kind_t;

  // architectural register number
  typedef logic [4:0] reg_idx_t;

  // one decoded instruction, immediate already extended
  typedef struct packed {
    fetch_pkg::pc_t pc;
    op_class_t      op;
    reg_idx_t       rd;
    reg_idx_t       rs1;
    logic [31:0]    imm;
  } decoded_t;

endpackage : decode_pkg

`default_nettype wire

// File: logic/fetch_pkg.sv
// fetch-side types; addresses and instruction words are fixed at 32 bits
`default_nettype none

package fetch_pkg;

  // byte address of an instruction
  typedef logic [31:0] pc_t;

  // raw instruction word
  typedef logic [31:0] instr_t;

  // one buffered fetch result
  typedef struct packed {
    pc_t    pc;
    instr_t instr;
  } fetch_entry_t;

endpackage : fetch_pkg

`default_nettype wire

// File: logic/frontend_defs.svh
// front-end constants; the field positions assume the fixed 32-bit instruction format
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// ==================================================
// fetch
// ==================================================
// boot address
`define FRONTEND_RESET_PC 32'h1C00_0000
`define FRONTEND_PC_STEP 32'd4

// instruction buffer, a power of two of 4 or more
`define FRONTEND_IBUF_DEPTH 8

// ==================================================
// instruction word fields
// ==================================================
`define FRONTEND_OP_MSB 31
`define FRONTEND_OP_LSB 26

// register fields are 5 bits wide
`define FRONTEND_RD_LSB 0
`define FRONTEND_RS1_LSB 5

`endif
